//--- compile.f
source/cache_pkg.sv
source/cache_if.sv
source/cache_arrays.sv
source/tag_lookup.sv
source/hit_datapath.sv
source/cache_control.sv
source/cache_top.sv
test/tb_mem_model.sv
test/tb_cache.sv

//--- source/cache_arrays.sv
// data, tag, valid and dirty storage for both ways with the reset sweep
`timescale 1ns/1ps
`default_nettype none

module cache_arrays (
    input  logic    clk,
    input  logic    resetn,
    lookup_if.array lk,
    line_if.array   ln,
    output logic    sweep_done
);
    import cache_pkg::*;

    line_t              data_mem  [ways][sets];
    logic [tag_w-1:0]   tag_mem   [ways][sets];
    logic               valid_mem [ways][sets];
    logic               dirty_mem [ways][sets];

    logic [index_w-1:0] sweep_cnt;

    // walk every set once after reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            sweep_cnt  <= '0;
            sweep_done <= 1'b0;
        end else if (!sweep_done) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (sweep_cnt == index_w'(sets - 1)) begin
                sweep_done <= 1'b1;
            end
        end
    end

    // status bits are cleared by the sweep, then follow line writes
    always_ff @(posedge clk) begin
        if (!sweep_done) begin
            for (int w = 0; w < ways; w++) begin
                valid_mem[w][sweep_cnt] <= 1'b0;
                dirty_mem[w][sweep_cnt] <= 1'b0;
            end
        end else if (ln.wr_en) begin
            valid_mem[ln.wr_way][ln.wr_index] <= ln.wr_valid;
            dirty_mem[ln.wr_way][ln.wr_index] <= ln.wr_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (ln.wr_en) begin
            data_mem[ln.wr_way][ln.wr_index] <= ln.wr_line;
            tag_mem[ln.wr_way][ln.wr_index]  <= ln.wr_tag;
        end
    end

    // asynchronous read of both ways
    always_comb begin
        for (int w = 0; w < ways; w++) begin
            lk.way_tag[w]   = tag_mem[w][lk.index];
            lk.way_valid[w] = valid_mem[w][lk.index];
            lk.way_dirty[w] = dirty_mem[w][lk.index];
            lk.way_line[w]  = data_mem[w][lk.index];
        end
    end

endmodule

`default_nettype wire

//--- source/cache_control.sv
// controller FSM with LFSR victim choice, write-back, line fill and uncached path
`timescale 1ns/1ps
`default_nettype none

module cache_control #(
    parameter logic [7:0] lfsr_seed = 8'h25
) (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         sweep_done,
    input  logic                         core_mem_valid,
    input  logic [cache_pkg::addr_w-1:0] core_mem_addr,
    input  logic [31:0]                  core_mem_wdata,
    input  logic [3:0]                   core_mem_wstrb,
    output logic                         core_mem_ready,
    output logic [31:0]                  core_mem_rdata,
    output logic                         mem_valid,
    output logic [cache_pkg::addr_w-1:0] mem_addr,
    output logic [31:0]                  mem_wdata,
    output logic [3:0]                   mem_wstrb,
    input  logic                         mem_ready,
    input  logic [31:0]                  mem_rdata,
    lookup_if.control                    lk,
    line_if.control                      ln,
    input  cache_pkg::line_t             merged_line,
    input  logic [31:0]                  hit_word,
    output cache_pkg::cache_addr_t       req_addr
);
    import cache_pkg::*;

    ctrl_state_t                   state;
    logic [7:0]                    lfsr;
    logic                          lfsr_fb;
    logic                          victim_way;
    logic [$clog2(line_words)-1:0] word_cnt;
    logic                          last_word;
    cache_addr_t                   core_addr;
    line_t                         victim_line;
    line_t                         fill_buf;
    line_t                         fill_line;

    // x^8 + x^6 + x^5 + x^4 + 1
    assign lfsr_fb     = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
    assign core_addr   = core_mem_addr;
    assign last_word   = (int'(word_cnt) == line_words - 1);
    assign victim_line = lk.way_line[victim_way];

    assign lk.index      = req_addr.cached.index;
    assign lk.req_tag    = req_addr.cached.tag;
    assign lk.victim_way = victim_way;

    // fill buffer with the word arriving this cycle already in place
    always_comb begin
        fill_line = fill_buf;
        fill_line[word_cnt*32 +: 32] = mem_rdata;
    end

    always_comb begin
        ln.wr_en    = 1'b0;
        ln.wr_way   = victim_way;
        ln.wr_index = req_addr.cached.index;
        ln.wr_line  = fill_line;
        ln.wr_tag   = req_addr.cached.tag;
        ln.wr_valid = 1'b1;
        ln.wr_dirty = 1'b0;
        if (state == st_lookup && lk.hit && |core_mem_wstrb) begin
            ln.wr_en    = 1'b1;
            ln.wr_way   = lk.hit_way;
            ln.wr_line  = merged_line;
            ln.wr_dirty = 1'b1;
        end else if (state == st_allocate && mem_valid && mem_ready && last_word) begin
            ln.wr_en = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state          <= st_sweep;
            lfsr           <= lfsr_seed;
            word_cnt       <= '0;
            core_mem_ready <= 1'b0;
            mem_valid      <= 1'b0;
        end else begin
            lfsr           <= {lfsr[6:0], lfsr_fb};
            core_mem_ready <= 1'b0;
            case (state)
                st_sweep: begin
                    if (sweep_done) begin
                        state <= st_idle;
                    end
                end
                st_idle: begin
                    // ready still high means the answered request is on the bus
                    if (core_mem_valid && !core_mem_ready) begin
                        req_addr   <= core_addr;
                        victim_way <= lfsr[0];
                        if (core_addr.io.region != '0) begin
                            mem_valid <= 1'b1;
                            mem_addr  <= core_mem_addr;
                            mem_wdata <= core_mem_wdata;
                            mem_wstrb <= core_mem_wstrb;
                            state     <= st_uncached;
                        end else begin
                            state <= st_lookup;
                        end
                    end
                end
                st_lookup: begin
                    word_cnt <= '0;
                    if (lk.hit) begin
                        core_mem_ready <= 1'b1;
                        core_mem_rdata <= hit_word;
                        state          <= st_idle;
                    end else if (lk.victim_dirty) begin
                        state <= st_write_back;
                    end else begin
                        state <= st_allocate;
                    end
                end
                st_write_back: begin
                    if (!mem_valid) begin
                        mem_valid <= 1'b1;
                        mem_addr  <= {lk.victim_tag, req_addr.cached.index, word_cnt, 2'b00};
                        mem_wdata <= victim_line[word_cnt*32 +: 32];
                        mem_wstrb <= 4'hf;
                    end else if (mem_ready) begin
                        mem_valid <= 1'b0;
                        word_cnt  <= word_cnt + 1'b1;
                        if (last_word) begin
                            state <= st_allocate;
                        end
                    end
                end
                st_allocate: begin
                    if (!mem_valid) begin
                        mem_valid <= 1'b1;
                        mem_addr  <= {req_addr.cached.tag, req_addr.cached.index,
                                      word_cnt, 2'b00};
                        mem_wstrb <= 4'h0;
                    end else if (mem_ready) begin
                        mem_valid <= 1'b0;
                        fill_buf  <= fill_line;
                        word_cnt  <= word_cnt + 1'b1;
                        // line is written this edge, lookup then hits
                        if (last_word) begin
                            state <= st_lookup;
                        end
                    end
                end
                st_uncached: begin
                    if (mem_ready) begin
                        mem_valid      <= 1'b0;
                        core_mem_ready <= 1'b1;
                        core_mem_rdata <= mem_rdata;
                        state          <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/cache_if.sv
// lookup interface and line-write interface with their modports
`timescale 1ns/1ps
`default_nettype none

interface lookup_if;
    import cache_pkg::*;

    // request side, from the controller
    logic [index_w-1:0]            index;
    logic [tag_w-1:0]              req_tag;
    logic                          victim_way;

    // both ways at the requested index
    logic [ways-1:0][tag_w-1:0]    way_tag;
    logic [ways-1:0]               way_valid;
    logic [ways-1:0]               way_dirty;
    line_t [ways-1:0]              way_line;

    // comparison results
    logic                          hit;
    logic                          hit_way;
    logic                          victim_dirty;
    logic [tag_w-1:0]              victim_tag;

    modport control (output index, req_tag, victim_way,
                     input hit, hit_way, victim_dirty, victim_tag, way_line);
    modport array   (input index,
                     output way_tag, way_valid, way_dirty, way_line);
    modport lookup  (input req_tag, victim_way, way_tag, way_valid, way_dirty,
                     output hit, hit_way, victim_dirty, victim_tag);
    modport result  (input hit_way, way_line);
endinterface

interface line_if;
    import cache_pkg::*;

    logic               wr_en;
    logic               wr_way;
    logic [index_w-1:0] wr_index;
    line_t              wr_line;
    logic [tag_w-1:0]   wr_tag;
    logic               wr_valid;
    logic               wr_dirty;

    modport control (output wr_en, wr_way, wr_index, wr_line, wr_tag, wr_valid, wr_dirty);
    modport array   (input wr_en, wr_way, wr_index, wr_line, wr_tag, wr_valid, wr_dirty);
endinterface

`default_nettype wire

//--- source/cache_pkg.sv
// cache geometry constants, address union and controller state type
`default_nettype none

package cache_pkg;

    localparam int addr_w     = 32;
    localparam int ways       = 2;
    localparam int line_words = 2;
    localparam int sets       = 64;
    localparam int offset_w   = 3;
    localparam int index_w    = 6;
    localparam int tag_w      = addr_w - index_w - offset_w;

    // one line holds all of its words side by side, word 0 in the low bits
    typedef logic [line_words*32-1:0] line_t;

    // cached view of an address
    typedef struct packed {
        logic [tag_w-1:0]                       tag;
        logic [index_w-1:0]                     index;
        logic [$clog2(line_words)-1:0]          word_sel;
        logic [offset_w-$clog2(line_words)-1:0] byte_off;
    } cached_addr_t;

    // region view, a nonzero region bypasses the cache
    typedef struct packed {
        logic [15:0] region;
        logic [15:0] low;
    } io_addr_t;

    typedef union packed {
        cached_addr_t cached;
        io_addr_t     io;
    } cache_addr_t;

    typedef enum logic [2:0] {
        st_sweep,
        st_idle,
        st_lookup,
        st_write_back,
        st_allocate,
        st_uncached
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/cache_top.sv
// cache top level with processor and memory ports
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
    parameter logic [7:0] lfsr_seed = 8'h25
) (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         core_mem_valid,
    input  logic [cache_pkg::addr_w-1:0] core_mem_addr,
    input  logic [cache_pkg::addr_w-1:0] core_mem_wdata,
    input  logic [3:0]                   core_mem_wstrb,
    output logic                         core_mem_ready,
    output logic [31:0]                  core_mem_rdata,
    output logic                         mem_valid,
    output logic [31:0]                  mem_addr,
    output logic [31:0]                  mem_wdata,
    output logic [3:0]                   mem_wstrb,
    input  logic                         mem_ready,
    input  logic [31:0]                  mem_rdata
);
    import cache_pkg::*;

    logic        sweep_done;
    line_t       merged_line;
    logic [31:0] hit_word;
    cache_addr_t req_addr;

    lookup_if lk_bus ();
    line_if   ln_bus ();

    cache_arrays u_arrays (
        .clk        (clk),
        .resetn     (resetn),
        .lk         (lk_bus.array),
        .ln         (ln_bus.array),
        .sweep_done (sweep_done)
    );

    tag_lookup u_lookup (
        .lk (lk_bus.lookup)
    );

    cache_control #(
        .lfsr_seed (lfsr_seed)
    ) u_control (
        .clk            (clk),
        .resetn         (resetn),
        .sweep_done     (sweep_done),
        .core_mem_valid (core_mem_valid),
        .core_mem_addr  (core_mem_addr),
        .core_mem_wdata (core_mem_wdata),
        .core_mem_wstrb (core_mem_wstrb),
        .core_mem_ready (core_mem_ready),
        .core_mem_rdata (core_mem_rdata),
        .mem_valid      (mem_valid),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_wstrb      (mem_wstrb),
        .mem_ready      (mem_ready),
        .mem_rdata      (mem_rdata),
        .lk             (lk_bus.control),
        .ln             (ln_bus.control),
        .merged_line    (merged_line),
        .hit_word       (hit_word),
        .req_addr       (req_addr)
    );

    hit_datapath u_datapath (
        .req_addr       (req_addr),
        .core_mem_wdata (core_mem_wdata),
        .core_mem_wstrb (core_mem_wstrb),
        .lk             (lk_bus.result),
        .merged_line    (merged_line),
        .hit_word       (hit_word)
    );

endmodule

`default_nettype wire

//--- source/hit_datapath.sv
// hit word select for reads and byte-strobe merge for writes
`timescale 1ns/1ps
`default_nettype none

module hit_datapath (
    input  cache_pkg::cache_addr_t req_addr,
    input  logic [31:0]            core_mem_wdata,
    input  logic [3:0]             core_mem_wstrb,
    lookup_if.result               lk,
    output cache_pkg::line_t       merged_line,
    output logic [31:0]            hit_word
);
    import cache_pkg::*;

    line_t                         hit_line;
    logic [$clog2(line_words)+4:0] word_base;

    assign hit_line  = lk.way_line[lk.hit_way];

    // bit position of the addressed word inside the line
    assign word_base = {req_addr.cached.word_sel, 5'd0};

    assign hit_word  = hit_line[word_base +: 32];

    // other words and unstrobed bytes keep their cached value
    always_comb begin
        merged_line = hit_line;
        for (int b = 0; b < 4; b++) begin
            if (core_mem_wstrb[b]) begin
                merged_line[word_base + b*8 +: 8] = core_mem_wdata[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/tag_lookup.sv
// per-way tag compare, hit way and victim status
`timescale 1ns/1ps
`default_nettype none

module tag_lookup (
    lookup_if.lookup lk
);
    import cache_pkg::*;

    logic [ways-1:0] way_match;

    for (genvar w = 0; w < ways; w++) begin : g_match
        assign way_match[w] = lk.way_valid[w] && (lk.way_tag[w] == lk.req_tag);
    end

    // a tag sits in at most one way, so the highest match wins harmlessly
    always_comb begin
        lk.hit     = 1'b0;
        lk.hit_way = 1'b0;
        for (int w = 0; w < ways; w++) begin
            if (way_match[w]) begin
                lk.hit     = 1'b1;
                lk.hit_way = 1'(w);
            end
        end
    end

    // only a valid dirty victim needs a write-back
    assign lk.victim_dirty = lk.way_valid[lk.victim_way] & lk.way_dirty[lk.victim_way];
    assign lk.victim_tag   = lk.way_tag[lk.victim_way];

endmodule

`default_nettype wire

//--- test/cache_vectors.txt
# name addr wdata strb chk exp_rdata exp_memops
# chk 1 compares the read data, exp_memops is the count of memory handshakes, ff skips it
# first fill, repeat hit and neighbour word of the same line
rd_first         00000100 00000000 0 1 5a5aa4a5 02
rd_repeat        00000100 00000000 0 1 5a5aa4a5 00
rd_neighbour     00000104 00000000 0 1 5a5aa4a1 00
# partial strobe write hit, bytes 0 and 2
wr_partial       00000104 11223344 5 0 00000000 00
rd_merged        00000104 00000000 0 1 5a22a444 00
# three tags on set 5 force evictions of dirty lines
wr_evict_a       00000228 aaaa0001 f 0 00000000 02
wr_evict_b       00000428 bbbb0002 f 0 00000000 ff
wr_evict_c       00000628 cccc0003 f 0 00000000 ff
rd_evict_a       00000228 00000000 0 1 aaaa0001 ff
rd_evict_a_next  0000022c 00000000 0 1 5a5aa789 ff
rd_evict_b       00000428 00000000 0 1 bbbb0002 ff
rd_evict_c       00000628 00000000 0 1 cccc0003 ff
rd_evict_c_next  0000062c 00000000 0 1 5a5aa389 ff
# uncacheable write and read back, one handshake each
wr_uncached      00010040 12345678 f 0 00000000 01
rd_uncached      00010040 00000000 0 1 12345678 01
# cached data survives an uncacheable access
wr_cached        00000300 deadbeef f 0 00000000 ff
rd_uncached_far  00020300 00000000 0 1 5a58a6a5 01
rd_cached_again  00000300 00000000 0 1 deadbeef 00
rd_merged_late   00000104 00000000 0 1 5a22a444 ff

//--- test/tb_cache.sv
// testbench top with clock, reset, vector reader, check task, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

    localparam int sweep_cycles = 64;

    logic        clk;
    logic        resetn;
    logic        core_mem_valid;
    logic [31:0] core_mem_addr;
    logic [31:0] core_mem_wdata;
    logic [3:0]  core_mem_wstrb;
    logic        core_mem_ready;
    logic [31:0] core_mem_rdata;
    logic        mem_valid;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic        mem_ready;
    logic [31:0] mem_rdata;

    // one entry per vector line
    string       vec_name   [$];
    logic [31:0] vec_addr   [$];
    logic [31:0] vec_wdata  [$];
    logic [3:0]  vec_wstrb  [$];
    logic        vec_chk    [$];
    logic [31:0] vec_rdata  [$];
    logic [7:0]  vec_memops [$];

    int          errors;
    int          mem_rises;
    logic        mem_valid_q;
    logic        vectors_ready;
    string       cur_name;
    logic [31:0] cur_addr;
    logic [31:0] cur_wdata;
    logic [3:0]  cur_wstrb;
    logic        cur_uncached;

    cache_top #(
        .lfsr_seed (8'h5c)
    ) u_dut (
        .clk            (clk),
        .resetn         (resetn),
        .core_mem_valid (core_mem_valid),
        .core_mem_addr  (core_mem_addr),
        .core_mem_wdata (core_mem_wdata),
        .core_mem_wstrb (core_mem_wstrb),
        .core_mem_ready (core_mem_ready),
        .core_mem_rdata (core_mem_rdata),
        .mem_valid      (mem_valid),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_wstrb      (mem_wstrb),
        .mem_ready      (mem_ready),
        .mem_rdata      (mem_rdata)
    );

    tb_mem_model u_mem (
        .clk       (clk),
        .resetn    (resetn),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    always #4 clk = ~clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [3:0]  strb;
        logic        chk;
        logic [7:0]  memops;
        fd = $fopen("test/cache_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file test/cache_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment and blank lines do not give all seven fields
                n = $sscanf(line, "%s %h %h %h %h %h %h",
                            name, addr, wdata, strb, chk, rdata, memops);
                if (n == 7) begin
                    vec_name.push_back(name);
                    vec_addr.push_back(addr);
                    vec_wdata.push_back(wdata);
                    vec_wstrb.push_back(strb);
                    vec_chk.push_back(chk);
                    vec_rdata.push_back(rdata);
                    vec_memops.push_back(memops);
                end
            end
            $fclose(fd);
        end
    endtask

    // puts one vector on the processor port
    task automatic drive_request(input int i);
        @(posedge clk);
        mem_rises      = 0;
        cur_name       = vec_name[i];
        cur_addr       = vec_addr[i];
        cur_wdata      = vec_wdata[i];
        cur_wstrb      = vec_wstrb[i];
        cur_uncached   = (vec_addr[i][31:16] != 16'h0);
        core_mem_valid <= 1'b1;
        core_mem_addr  <= vec_addr[i];
        core_mem_wdata <= vec_wdata[i];
        core_mem_wstrb <= vec_wstrb[i];
    endtask

    // waits for the answer, releases the port and checks the result
    task automatic finish_request(input int i);
        logic [31:0] rdata;
        do begin
            @(negedge clk);
        end while (core_mem_ready !== 1'b1);
        rdata = core_mem_rdata;
        @(posedge clk);
        core_mem_valid <= 1'b0;
        if (vec_chk[i]) begin
            check(vec_name[i], vec_rdata[i], rdata);
        end
        // ff in the memops column leaves the handshake count open
        if (vec_memops[i] != 8'hff) begin
            check({vec_name[i], "_memops"}, 32'(vec_memops[i]), 32'(mem_rises));
        end
    endtask

    // counts memory handshakes
    // an uncached one carries the processor request unchanged
    always @(negedge clk) begin
        if (mem_valid === 1'b1 && mem_valid_q !== 1'b1) begin
            mem_rises = mem_rises + 1;
            if (cur_uncached) begin
                check({cur_name, "_mem_addr"}, cur_addr, mem_addr);
                check({cur_name, "_mem_wdata"}, cur_wdata, mem_wdata);
                check({cur_name, "_mem_wstrb"}, 32'(cur_wstrb), 32'(mem_wstrb));
            end
        end
        mem_valid_q = mem_valid;
    end

    initial begin
        wait (vectors_ready);
        repeat (vec_name.size() * 200 + 1000) @(posedge clk);
        $display("timeout: the cache did not finish the vectors in time");
        $display("summary: %0d errors before the timeout", errors);
        $display("Errors found");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        resetn         = 1'b0;
        core_mem_valid = 1'b0;
        core_mem_addr  = '0;
        core_mem_wdata = '0;
        core_mem_wstrb = '0;
        errors         = 0;
        mem_rises      = 0;
        mem_valid_q    = 1'b0;
        cur_name       = "";
        cur_addr       = '0;
        cur_wdata      = '0;
        cur_wstrb      = '0;
        cur_uncached   = 1'b0;
        vectors_ready  = 1'b0;
        load_vectors();
        vectors_ready = 1'b1;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        // the first request already waits on the port during the sweep
        if (vec_name.size() > 0) begin
            drive_request(0);
        end
        // both handshakes stay quiet while the sets are invalidated
        repeat (sweep_cycles) begin
            @(negedge clk);
            check("sweep_core_ready", 32'd0, 32'(core_mem_ready));
            check("sweep_mem_valid", 32'd0, 32'(mem_valid));
        end
        if (vec_name.size() == 0) begin
            $display("no vectors were read, nothing was tested");
            errors++;
        end else begin
            for (int i = 0; i < vec_name.size(); i++) begin
                if (i > 0) begin
                    drive_request(i);
                end
                finish_request(i);
            end
        end
        $display("summary: %0d vectors, %0d errors", vec_name.size(), errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tb_mem_model.sv
// behavioral memory controller with random ready delay and address-patterned content
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
    parameter logic [31:0] fill_pattern = 32'h5a5a_a5a5
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        mem_valid,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    input  logic [3:0]  mem_wstrb,
    output logic        mem_ready,
    output logic [31:0] mem_rdata
);

    // only written words are stored, the rest follow the fill pattern
    logic [31:0] words [logic [31:0]];
    logic [1:0]  delay;
    integer      seed;
    integer      rnd;

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] key;
        key = {addr[31:2], 2'b00};
        if (words.exists(key)) begin
            return words[key];
        end
        return key ^ fill_pattern;
    endfunction

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic [31:0] key;
        logic [31:0] word;
        key  = {addr[31:2], 2'b00};
        word = read_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        words[key] = word;
    endtask

    initial begin
        seed      = 71031;
        mem_ready = 1'b0;
        mem_rdata = '0;
    end

    // one word per handshake, ready pulses after 0 to 3 wait cycles
    always @(posedge clk) begin
        mem_ready <= 1'b0;
        if (!resetn) begin
            rnd   = $random(seed);
            delay <= rnd[1:0];
        end else if (mem_valid && !mem_ready) begin
            if (delay == 2'd0) begin
                if (|mem_wstrb) begin
                    write_word(mem_addr, mem_wdata, mem_wstrb);
                end else begin
                    mem_rdata <= read_word(mem_addr);
                end
                mem_ready <= 1'b1;
                rnd = $random(seed);
                delay <= rnd[1:0];
            end else begin
                delay <= delay - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire
